// File: rtl/uart_pkg.sv
package uart_pkg;

    //////////////////////////////////////////////////////////////////////
    // Frame options
    //////////////////////////////////////////////////////////////////////

    // Parity bit rule appended after the data bits
    typedef enum logic [2:0]
    {
        PARITY_NONE  = 3'd0,
        PARITY_EVEN  = 3'd1,
        PARITY_ODD   = 3'd2,
        PARITY_MARK  = 3'd3,
        PARITY_SPACE = 3'd4
    } parity_mode_t;

    //////////////////////////////////////////////////////////////////////
    // Default frame constants
    //////////////////////////////////////////////////////////////////////

    localparam int DEF_CLKS_PER_BIT = 434;  // 50 MHz clock at 115200 baud
    localparam int DEF_DATA_BITS    = 8;
    localparam int DEF_STOP_BITS    = 1;
    localparam int DEF_FIFO_DEPTH   = 16;

    // Widest data field the shift registers support
    localparam int MAX_DATA_BITS    = 9;

endpackage

// File: rtl/uart_bit_timer.sv
`timescale 1ns/100ps

module uart_bit_timer
    import uart_pkg::*;
#(
    parameter int CLKS_PER_BIT = DEF_CLKS_PER_BIT
)
(
    input  logic clk,
    input  logic rst,
    input  logic run,
    output logic mid_tick,
    output logic bit_tick
);

    localparam int CNT_W = $clog2(CLKS_PER_BIT);

    logic [CNT_W-1:0] count;

    // Free running within one bit period, parked at zero when idle
    always_ff @(posedge clk)
    begin
        if (rst || !run)
        begin
            count <= '0;
        end
        else if (count == CNT_W'(CLKS_PER_BIT - 1))
        begin
            count <= '0;                            // Wrap into next bit
        end
        else
        begin
            count <= count + 1'b1;
        end
    end

    assign mid_tick = run && (count == CNT_W'(CLKS_PER_BIT / 2));  // Sample point
    assign bit_tick = run && (count == CNT_W'(CLKS_PER_BIT - 1));  // Last cycle of bit

    // Shorter periods leave no room between mid and end strobes
    a_min_period: assert property (@(posedge clk) CLKS_PER_BIT >= 4)
        else $error("CLKS_PER_BIT must be at least 4");

endmodule

// File: rtl/uart_tx.sv
`timescale 1ns/100ps

module uart_tx
    import uart_pkg::*;
#(
    parameter int           DATA_BITS = DEF_DATA_BITS,
    parameter parity_mode_t PARITY    = PARITY_EVEN,
    parameter int           STOP_BITS = DEF_STOP_BITS
)
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 tx_data_ready,
    input  logic [DATA_BITS-1:0] tx_data,
    output logic                 tx_data_copied,
    output logic                 tx_busy,
    output logic                 tx,
    output logic                 run,
    input  logic                 bit_tick
);

    localparam int CNT_W = $clog2(DATA_BITS);

    localparam logic [2:0] S_IDLE   = 3'd0;
    localparam logic [2:0] S_START  = 3'd1;
    localparam logic [2:0] S_DATA   = 3'd2;
    localparam logic [2:0] S_PARITY = 3'd3;
    localparam logic [2:0] S_STOP   = 3'd4;

    logic [2:0]           state;
    logic [DATA_BITS-1:0] shift;        // Remaining data bits, LSB next
    logic [CNT_W-1:0]     data_cnt;     // Index of bit now on the line
    logic                 stop_cnt;
    logic                 parity_acc;   // XOR of bits sent so far
    logic                 parity_bit;

    always_comb
    begin
        case (PARITY)
            PARITY_EVEN: parity_bit = parity_acc;
            PARITY_ODD:  parity_bit = ~parity_acc;
            PARITY_MARK: parity_bit = 1'b1;
            default:     parity_bit = 1'b0;
        endcase
    end

    assign run = (state != S_IDLE);

    //////////////////////////////////////////////////////////////////////
    // Frame sequencer
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state          <= S_IDLE;
            tx             <= 1'b1;
            tx_busy        <= 1'b0;
            tx_data_copied <= 1'b0;
            data_cnt       <= '0;
            stop_cnt       <= 1'b0;
            parity_acc     <= 1'b0;
        end
        else
        begin
            tx_data_copied <= 1'b0;
            case (state)
                S_IDLE:
                begin
                    tx      <= 1'b1;
                    tx_busy <= 1'b0;
                    if (tx_data_ready)
                    begin
                        shift          <= tx_data;
                        tx             <= 1'b0;         // Start bit
                        tx_busy        <= 1'b1;
                        tx_data_copied <= 1'b1;
                        state          <= S_START;
                    end
                end
                S_START:
                begin
                    if (bit_tick)
                    begin
                        tx         <= shift[0];
                        parity_acc <= shift[0];
                        shift      <= shift >> 1;
                        data_cnt   <= '0;
                        state      <= S_DATA;
                    end
                end
                S_DATA:
                begin
                    if (bit_tick)
                    begin
                        if (data_cnt == CNT_W'(DATA_BITS - 1))
                        begin
                            if (PARITY == PARITY_NONE)
                            begin
                                tx       <= 1'b1;
                                stop_cnt <= 1'b0;
                                state    <= S_STOP;
                            end
                            else
                            begin
                                tx    <= parity_bit;
                                state <= S_PARITY;
                            end
                        end
                        else
                        begin
                            tx         <= shift[0];
                            parity_acc <= parity_acc ^ shift[0];
                            shift      <= shift >> 1;
                            data_cnt   <= data_cnt + 1'b1;
                        end
                    end
                end
                S_PARITY:
                begin
                    if (bit_tick)
                    begin
                        tx       <= 1'b1;
                        stop_cnt <= 1'b0;
                        state    <= S_STOP;
                    end
                end
                S_STOP:
                begin
                    if (bit_tick)
                    begin
                        if (stop_cnt == 1'(STOP_BITS - 1))
                        begin
                            state <= S_IDLE;        // Busy drops one cycle later
                        end
                        else
                        begin
                            stop_cnt <= 1'b1;
                        end
                    end
                end
                default:
                begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

    a_params: assert property (@(posedge clk)
        DATA_BITS >= 5 && DATA_BITS <= MAX_DATA_BITS && STOP_BITS inside {1, 2});
    a_copied_pulse: assert property (@(posedge clk) disable iff (rst)
        tx_data_copied |=> !tx_data_copied);
    a_line_idle: assert property (@(posedge clk) disable iff (rst) !tx_busy |-> tx);

endmodule

// File: rtl/uart_rx.sv
`timescale 1ns/100ps

module uart_rx
    import uart_pkg::*;
#(
    parameter int           DATA_BITS = DEF_DATA_BITS,
    parameter parity_mode_t PARITY    = PARITY_EVEN
)
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 rx,
    output logic                 run,
    input  logic                 mid_tick,
    output logic                 push,
    output logic [DATA_BITS-1:0] push_data,
    output logic                 rx_err
);

    localparam int CNT_W = $clog2(DATA_BITS);

    localparam logic [2:0] S_IDLE   = 3'd0;
    localparam logic [2:0] S_START  = 3'd1;
    localparam logic [2:0] S_DATA   = 3'd2;
    localparam logic [2:0] S_PARITY = 3'd3;
    localparam logic [2:0] S_STOP   = 3'd4;

    logic                 rx_meta;
    logic                 rx_sync;
    logic                 rx_prev;      // For falling edge detect
    logic [2:0]           state;
    logic [DATA_BITS-1:0] shift;
    logic [CNT_W-1:0]     data_cnt;
    logic                 parity_acc;
    logic                 parity_bad;
    logic                 parity_exp;

    //////////////////////////////////////////////////////////////////////
    // Line synchronizer
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
            rx_prev <= 1'b1;
        end
        else
        begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
            rx_prev <= rx_sync;
        end
    end

    always_comb
    begin
        case (PARITY)
            PARITY_EVEN: parity_exp = parity_acc;
            PARITY_ODD:  parity_exp = ~parity_acc;
            PARITY_MARK: parity_exp = 1'b1;
            default:     parity_exp = 1'b0;
        endcase
    end

    assign run       = (state != S_IDLE);
    assign push_data = shift;

    //////////////////////////////////////////////////////////////////////
    // Frame sampler
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state      <= S_IDLE;
            data_cnt   <= '0;
            parity_acc <= 1'b0;
            parity_bad <= 1'b0;
            push       <= 1'b0;
            rx_err     <= 1'b0;
        end
        else
        begin
            push   <= 1'b0;
            rx_err <= 1'b0;
            case (state)
                S_IDLE:
                begin
                    parity_acc <= 1'b0;
                    parity_bad <= 1'b0;
                    if (rx_prev && !rx_sync)    // Needs a high line before each start
                    begin
                        state <= S_START;
                    end
                end
                S_START:
                begin
                    if (mid_tick)
                    begin
                        data_cnt <= '0;
                        // Glitch shorter than half a bit is dropped quietly
                        state    <= rx_sync ? S_IDLE : S_DATA;
                    end
                end
                S_DATA:
                begin
                    if (mid_tick)
                    begin
                        shift      <= {rx_sync, shift[DATA_BITS-1:1]};  // LSB first
                        parity_acc <= parity_acc ^ rx_sync;
                        data_cnt   <= data_cnt + 1'b1;
                        if (data_cnt == CNT_W'(DATA_BITS - 1))
                        begin
                            state <= (PARITY == PARITY_NONE) ? S_STOP : S_PARITY;
                        end
                    end
                end
                S_PARITY:
                begin
                    if (mid_tick)
                    begin
                        parity_bad <= (rx_sync != parity_exp);
                        state      <= S_STOP;
                    end
                end
                S_STOP:
                begin
                    if (mid_tick)
                    begin
                        if (rx_sync && !parity_bad)
                        begin
                            push <= 1'b1;
                        end
                        else
                        begin
                            rx_err <= 1'b1;     // Bad parity or framing
                        end
                        state <= S_IDLE;
                    end
                end
                default:
                begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

    a_params: assert property (@(posedge clk) DATA_BITS >= 5 && DATA_BITS <= MAX_DATA_BITS);
    a_one_outcome: assert property (@(posedge clk) disable iff (rst) !(push && rx_err));

endmodule

// File: rtl/uart_rx_fifo.sv
`timescale 1ns/100ps

module uart_rx_fifo
    import uart_pkg::*;
#(
    parameter int DATA_BITS  = DEF_DATA_BITS,
    parameter int FIFO_DEPTH = DEF_FIFO_DEPTH
)
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 push,
    input  logic [DATA_BITS-1:0] push_data,
    input  logic                 pop,
    output logic [DATA_BITS-1:0] pop_data,
    output logic                 not_empty,
    output logic                 overrun
);

    localparam int ADDR_W = $clog2(FIFO_DEPTH);

    logic [DATA_BITS-1:0] mem [FIFO_DEPTH];
    logic [ADDR_W-1:0]    wr_ptr;
    logic [ADDR_W-1:0]    rd_ptr;
    logic [ADDR_W:0]      count;
    logic                 full;
    logic                 do_push;
    logic                 do_pop;

    assign full      = (count == (ADDR_W + 1)'(FIFO_DEPTH));
    assign not_empty = (count != '0);
    assign do_push   = push && !full;      // Full buffer drops the byte
    assign do_pop    = pop && not_empty;
    assign pop_data  = mem[rd_ptr];        // Oldest entry shown ahead of the pop

    always_ff @(posedge clk)
    begin
        if (do_push)
        begin
            mem[wr_ptr] <= push_data;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Pointers and occupancy
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count   <= '0;
            overrun <= 1'b0;
        end
        else
        begin
            overrun <= push && full;
            if (do_push)
            begin
                wr_ptr <= wr_ptr + 1'b1;   // Wraps at power-of-two depth
            end
            if (do_pop)
            begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    a_params: assert property (@(posedge clk) FIFO_DEPTH >= 2 &&
        (FIFO_DEPTH & (FIFO_DEPTH - 1)) == 0 && DATA_BITS <= MAX_DATA_BITS);
    a_count_bound: assert property (@(posedge clk) disable iff (rst)
        count <= (ADDR_W + 1)'(FIFO_DEPTH));

endmodule

// File: rtl/uart_top.sv
`timescale 1ns/100ps

module uart_top
    import uart_pkg::*;
#(
    parameter int           CLKS_PER_BIT = DEF_CLKS_PER_BIT,
    parameter int           DATA_BITS    = DEF_DATA_BITS,
    parameter parity_mode_t PARITY       = PARITY_EVEN,
    parameter int           STOP_BITS    = DEF_STOP_BITS,
    parameter int           FIFO_DEPTH   = DEF_FIFO_DEPTH
)
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 rx,
    output logic                 tx,
    input  logic                 rx_read,
    output logic [DATA_BITS-1:0] rx_data,
    output logic                 rx_avail,
    output logic                 rx_err,
    output logic                 rx_overrun,
    input  logic                 tx_data_ready,
    input  logic [DATA_BITS-1:0] tx_data,
    output logic                 tx_data_copied,
    output logic                 tx_busy
);

    logic                 tx_run;
    logic                 tx_bit_tick;
    logic                 rx_run;
    logic                 rx_mid_tick;
    logic                 rx_push;
    logic [DATA_BITS-1:0] rx_push_data;

    // Transmit path, strobed at the end of each bit
    uart_bit_timer #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_tx_timer
    (
        .clk      (clk),
        .rst      (rst),
        .run      (tx_run),
        .mid_tick (),
        .bit_tick (tx_bit_tick)
    );

    uart_tx #(.DATA_BITS(DATA_BITS), .PARITY(PARITY), .STOP_BITS(STOP_BITS)) u_tx
    (
        .clk            (clk),
        .rst            (rst),
        .tx_data_ready  (tx_data_ready),
        .tx_data        (tx_data),
        .tx_data_copied (tx_data_copied),
        .tx_busy        (tx_busy),
        .tx             (tx),
        .run            (tx_run),
        .bit_tick       (tx_bit_tick)
    );

    // Receive path, sampled mid bit
    uart_bit_timer #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_rx_timer
    (
        .clk      (clk),
        .rst      (rst),
        .run      (rx_run),
        .mid_tick (rx_mid_tick),
        .bit_tick ()
    );

    uart_rx #(.DATA_BITS(DATA_BITS), .PARITY(PARITY)) u_rx
    (
        .clk       (clk),
        .rst       (rst),
        .rx        (rx),
        .run       (rx_run),
        .mid_tick  (rx_mid_tick),
        .push      (rx_push),
        .push_data (rx_push_data),
        .rx_err    (rx_err)
    );

    uart_rx_fifo #(.DATA_BITS(DATA_BITS), .FIFO_DEPTH(FIFO_DEPTH)) u_rx_fifo
    (
        .clk       (clk),
        .rst       (rst),
        .push      (rx_push),
        .push_data (rx_push_data),
        .pop       (rx_read),
        .pop_data  (rx_data),
        .not_empty (rx_avail),
        .overrun   (rx_overrun)
    );

endmodule

// File: bench/uart_checker.sv
`timescale 1ns/100ps

module uart_checker
    import uart_pkg::*;
#(
    parameter int CLKS_PER_BIT = 16,
    parameter int DATA_BITS    = 8,
    parameter int FRAME_BITS   = 12,
    parameter int TX_FRAMES    = 8
)
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  tx,
    input  logic                  tx_busy,
    input  logic                  tx_data_copied,
    input  logic [FRAME_BITS-1:0] exp_frame,
    input  logic                  rx_read,
    input  logic [DATA_BITS-1:0]  rx_data,
    input  logic                  rx_avail,
    input  logic                  rx_err,
    input  logic                  rx_overrun,
    input  logic                  exp_push,
    input  logic [DATA_BITS-1:0]  exp_byte,
    input  logic                  exp_err,
    input  logic                  exp_ovr,
    input  logic                  expect_empty,
    input  logic                  done,
    input  int                    timeout_count,
    output int                    error_count
);

    logic [DATA_BITS-1:0]  exp_q[$];    // Bytes the FIFO should hand out in order
    logic [DATA_BITS-1:0]  want;
    logic [FRAME_BITS-1:0] frame_exp;
    logic [FRAME_BITS-1:0] frame_got;
    logic                  tx_prev;
    logic                  in_frame;
    logic                  reported;
    int                    since_fall;
    int                    busy_len;
    int                    frames;
    int                    copied_cnt;
    int                    busy_ends;
    int                    err_seen;
    int                    err_want;
    int                    ovr_seen;
    int                    ovr_want;
    int                    checks;
    int                    errors;

    assign error_count = errors;

    task automatic compare_count(input string name, input int expected, input int actual);
        checks++;
        if (expected != actual)
        begin
            errors++;
            $display("[FAIL] %s: expected %0d, actual %0d", name, expected, actual);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Sampling on the falling edge away from register updates
    //////////////////////////////////////////////////////////////////////

    always @(negedge clk)
    begin
        if (rst)
        begin
            exp_q.delete();
            frame_exp  = '0;
            frame_got  = '0;
            tx_prev    = 1'b1;
            in_frame   = 1'b0;
            reported   = 1'b0;
            since_fall = 0;
            busy_len   = 0;
            frames     = 0;
            copied_cnt = 0;
            busy_ends  = 0;
            err_seen   = 0;
            err_want   = 0;
            ovr_seen   = 0;
            ovr_want   = 0;
            checks     = 0;
            errors     = 0;
        end
        else
        begin
            // Tx frame decode with one sample in the middle of each bit
            if (in_frame)
            begin
                since_fall++;
                if (since_fall % CLKS_PER_BIT == CLKS_PER_BIT / 2)
                begin
                    frame_got[since_fall / CLKS_PER_BIT] = tx;
                    if (since_fall / CLKS_PER_BIT == FRAME_BITS - 1)
                    begin
                        in_frame = 1'b0;
                        frames++;
                        checks++;
                        if (frame_got !== frame_exp)
                        begin
                            errors++;
                            $display("[FAIL] tx_frame: expected %b, actual %b",
                                     frame_exp, frame_got);
                        end
                    end
                end
            end
            else if (tx_prev && !tx)
            begin
                in_frame   = 1'b1;
                since_fall = 0;
                frame_exp  = exp_frame;   // Byte still held at the copied pulse
            end
            tx_prev = tx;

            if (!tx_busy && !tx)
            begin
                errors++;
                $display("tx line is low while the transmitter is idle");
            end
            if (tx_busy)
            begin
                busy_len++;
            end
            else if (busy_len != 0)
            begin
                compare_count("tx_busy_length", FRAME_BITS * CLKS_PER_BIT + 1, busy_len);
                busy_ends++;
                busy_len = 0;
            end
            if (tx_data_copied)
            begin
                copied_cnt++;                 // Counts cycles so a wide pulse shows up
            end

            // Receive side bookkeeping
            if (exp_push)
            begin
                exp_q.push_back(exp_byte);
            end
            if (exp_err)
            begin
                err_want++;
            end
            if (exp_ovr)
            begin
                ovr_want++;
            end
            if (rx_err)
            begin
                err_seen++;
            end
            if (rx_overrun)
            begin
                ovr_seen++;
            end
            if (expect_empty && rx_avail)
            begin
                errors++;
                $display("rx_avail is high while the receive FIFO should be empty");
            end
            if (rx_read && rx_avail)
            begin
                if (exp_q.size() == 0)
                begin
                    errors++;
                    $display("A byte was read from the FIFO when none was expected");
                end
                else
                begin
                    want = exp_q.pop_front();
                    checks++;
                    if (rx_data !== want)
                    begin
                        errors++;
                        $display("[FAIL] rx_data: expected %h, actual %h", want, rx_data);
                    end
                end
            end

            if (done && !reported)
            begin
                reported = 1'b1;
                if (exp_q.size() != 0)
                begin
                    errors++;
                    $display("%0d expected bytes were never read from the FIFO", exp_q.size());
                end
                compare_count("tx_frame_count", TX_FRAMES, frames);
                compare_count("tx_copied_count", TX_FRAMES, copied_cnt);
                compare_count("tx_busy_count", TX_FRAMES, busy_ends);
                compare_count("rx_err_count", err_want, err_seen);
                compare_count("rx_overrun_count", ovr_want, ovr_seen);
                $display("Checker summary: %0d checks, %0d errors, %0d timeouts",
                         checks, errors, timeout_count);
            end
        end
    end

endmodule

// File: bench/tb_uart.sv
`timescale 1ns/100ps

module tb_uart
    import uart_pkg::*;
();

    localparam int           CLKS       = 16;
    localparam int           DATA_BITS  = 8;
    localparam parity_mode_t PARITY     = PARITY_EVEN;
    localparam int           STOP_BITS  = 2;
    localparam int           FIFO_DEPTH = 4;
    localparam int           TX_FRAMES  = 8;
    localparam int           PAR_BITS   = (PARITY == PARITY_NONE) ? 0 : 1;
    localparam int           FRAME_BITS = 1 + DATA_BITS + PAR_BITS + STOP_BITS;
    localparam int           WAIT_LIMIT = 4 * FRAME_BITS * CLKS;   // Cycles before giving up

    logic                  clk;
    logic                  rst;
    logic                  rx;
    logic                  tx;
    logic                  rx_read;
    logic [DATA_BITS-1:0]  rx_data;
    logic                  rx_avail;
    logic                  rx_err;
    logic                  rx_overrun;
    logic                  tx_data_ready;
    logic [DATA_BITS-1:0]  tx_data;
    logic                  tx_data_copied;
    logic                  tx_busy;

    logic [FRAME_BITS-1:0] exp_frame;      // Expected line bits for the byte on tx_data
    logic                  exp_push;
    logic [DATA_BITS-1:0]  exp_byte;
    logic                  exp_err;
    logic                  exp_ovr;
    logic                  expect_empty;
    logic                  done;
    int                    error_count;
    int                    timeout_count;
    logic [15:0]           lfsr;

    //////////////////////////////////////////////////////////////////////
    // Reference model and stimulus helpers
    //////////////////////////////////////////////////////////////////////

    // Galois form with taps x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    task automatic random_byte(output logic [DATA_BITS-1:0] b);
        for (int i = 0; i < DATA_BITS; i++)
        begin
            lfsr = lfsr_step(lfsr);
            b[i] = lfsr[0];             // One step per bit taken
        end
    endtask

    // Bit 0 is the start bit, then data LSB first, parity, stop bits
    function automatic logic [FRAME_BITS-1:0] frame_bits(input logic [DATA_BITS-1:0] data,
                                                         input logic bad_parity,
                                                         input logic bad_stop);
        logic [FRAME_BITS-1:0] f;
        logic                  ones_odd;
        ones_odd = ^data;
        f        = '1;
        f[0]     = 1'b0;
        for (int i = 0; i < DATA_BITS; i++)
        begin
            f[1 + i] = data[i];
        end
        case (PARITY)
            PARITY_EVEN:  f[DATA_BITS + 1] = ones_odd ^ bad_parity;   // Total ones even
            PARITY_ODD:   f[DATA_BITS + 1] = ~ones_odd ^ bad_parity;
            PARITY_MARK:  f[DATA_BITS + 1] = ~bad_parity;
            PARITY_SPACE: f[DATA_BITS + 1] = bad_parity;
            default:      ;
        endcase
        if (bad_stop)
        begin
            f[FRAME_BITS - STOP_BITS] = 1'b0;   // First stop bit is the one checked
        end
        return f;
    endfunction

    assign exp_frame = frame_bits(tx_data, 1'b0, 1'b0);

    task automatic note_timeout(input string what);
        $display("Timeout: %s", what);
        timeout_count++;
    endtask

    task automatic send_byte(input logic [DATA_BITS-1:0] b);
        int n;
        tx_data       <= b;
        tx_data_ready <= 1'b1;
        n = 0;
        do
        begin
            @(posedge clk);
            n++;
        end
        while (!tx_data_copied && n < WAIT_LIMIT);
        if (!tx_data_copied)
        begin
            note_timeout("tx_data_copied never pulsed after a transmit request");
        end
        tx_data_ready <= 1'b0;
        n = 0;
        do
        begin
            @(posedge clk);
            n++;
        end
        while (tx_busy && n < WAIT_LIMIT);
        if (tx_busy)
        begin
            note_timeout("tx_busy stayed high after a transmit frame");
        end
    endtask

    task automatic drive_frame(input logic [DATA_BITS-1:0] b, input logic bad_parity,
                               input logic bad_stop);
        logic [FRAME_BITS-1:0] f;
        f = frame_bits(b, bad_parity, bad_stop);
        for (int i = 0; i < FRAME_BITS; i++)
        begin
            rx <= f[i];
            repeat (CLKS) @(posedge clk);
        end
    endtask

    // Tells the checker what the next rx frame should produce
    task automatic expect_outcome(input logic [DATA_BITS-1:0] b, input logic stored,
                                  input logic err, input logic ovr);
        exp_byte <= b;
        exp_push <= stored;
        exp_err  <= err;
        exp_ovr  <= ovr;
        @(posedge clk);
        exp_push <= 1'b0;
        exp_err  <= 1'b0;
        exp_ovr  <= 1'b0;
    endtask

    task automatic read_byte();
        int n;
        n = 0;
        do
        begin
            @(posedge clk);
            n++;
        end
        while (!rx_avail && n < WAIT_LIMIT);
        if (!rx_avail)
        begin
            note_timeout("rx_avail never rose for an expected byte");
        end
        else
        begin
            rx_read <= 1'b1;
            @(posedge clk);
            rx_read <= 1'b0;
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // DUT and checker
    //////////////////////////////////////////////////////////////////////

    uart_top #(
        .CLKS_PER_BIT (CLKS),
        .DATA_BITS    (DATA_BITS),
        .PARITY       (PARITY),
        .STOP_BITS    (STOP_BITS),
        .FIFO_DEPTH   (FIFO_DEPTH)
    ) u_uart_top
    (
        .clk            (clk),
        .rst            (rst),
        .rx             (rx),
        .tx             (tx),
        .rx_read        (rx_read),
        .rx_data        (rx_data),
        .rx_avail       (rx_avail),
        .rx_err         (rx_err),
        .rx_overrun     (rx_overrun),
        .tx_data_ready  (tx_data_ready),
        .tx_data        (tx_data),
        .tx_data_copied (tx_data_copied),
        .tx_busy        (tx_busy)
    );

    uart_checker #(
        .CLKS_PER_BIT (CLKS),
        .DATA_BITS    (DATA_BITS),
        .FRAME_BITS   (FRAME_BITS),
        .TX_FRAMES    (TX_FRAMES)
    ) u_checker (.*);

    initial
    begin
        clk = 1'b0;
        forever
        begin
            #5 clk = ~clk;
        end
    end

    initial
    begin
        logic [DATA_BITS-1:0] b;
        rst           = 1'b1;
        rx            = 1'b1;      // Line idles high
        rx_read       = 1'b0;
        tx_data_ready = 1'b0;
        tx_data       = '0;
        exp_push      = 1'b0;
        exp_byte      = '0;
        exp_err       = 1'b0;
        exp_ovr       = 1'b0;
        expect_empty  = 1'b0;
        done          = 1'b0;
        timeout_count = 0;
        lfsr          = 16'd76;
        repeat (3) @(posedge clk);
        rst <= 1'b0;

        // Transmit frames that the checker decodes and times
        for (int k = 0; k < TX_FRAMES; k++)
        begin
            random_byte(b);
            send_byte(b);
        end

        // Good receive frames read back in order
        for (int k = 0; k < 3; k++)
        begin
            random_byte(b);
            expect_outcome(b, 1'b1, 1'b0, 1'b0);
            drive_frame(b, 1'b0, 1'b0);
        end
        repeat (3) read_byte();

        // Inverted parity bit
        random_byte(b);
        expect_empty <= 1'b1;
        expect_outcome(b, 1'b0, 1'b1, 1'b0);
        drive_frame(b, 1'b1, 1'b0);
        repeat (CLKS) @(posedge clk);
        expect_empty <= 1'b0;

        // Low stop bit followed by a good frame
        random_byte(b);
        expect_outcome(b, 1'b0, 1'b1, 1'b0);
        drive_frame(b, 1'b0, 1'b1);
        random_byte(b);
        expect_outcome(b, 1'b1, 1'b0, 1'b0);
        drive_frame(b, 1'b0, 1'b0);
        read_byte();

        // One frame more than the FIFO holds
        for (int k = 0; k <= FIFO_DEPTH; k++)
        begin
            random_byte(b);
            expect_outcome(b, k < FIFO_DEPTH, 1'b0, k == FIFO_DEPTH);
            drive_frame(b, 1'b0, 1'b0);
        end
        repeat (FIFO_DEPTH) read_byte();
        expect_empty <= 1'b1;
        repeat (2 * CLKS) @(posedge clk);
        expect_empty <= 1'b0;

        done <= 1'b1;
        repeat (2) @(posedge clk);
        if (error_count == 0 && timeout_count == 0)
        begin
            $display("Test completed successfully");
        end
        else
        begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: compile.f
rtl/uart_pkg.sv
rtl/uart_bit_timer.sv
rtl/uart_tx.sv
rtl/uart_rx.sv
rtl/uart_rx_fifo.sv
rtl/uart_top.sv
bench/uart_checker.sv
bench/tb_uart.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing
TOP       := tb_uart
FILELIST  := compile.f
BUILD_DIR := obj_dir
LOG       := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "Test failed" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@grep -q "Test completed successfully" $(LOG) || (echo "No pass line in $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
